/* hw/usbPacketPkg.sv */
package usbPacketPkg;

    // ======================================================================
    // PID field
    // ======================================================================

    // PID nibble, the low half of the PID byte and sent first
    typedef logic [3:0] pid_t;

    // SYNC is KJKJKJKK on the line
    // After NRZI decoding that is seven zeros and a one, shifted in LSB first
    localparam logic [7:0] SYNC_PATTERN = 8'b1000_0000;

    // DATA0, DATA1, DATA2 and MDATA all end in 2'b11
    // Only these packets carry a CRC16
    localparam logic [1:0] DATA_PID_MASK = 2'b11;

    // ======================================================================
    // CRC residues
    // ======================================================================

    // Remainder left after shifting a token field plus its CRC5
    localparam logic [4:0] CRC5_RESIDUE = 5'b01100;

    // Remainder left after shifting a data payload plus its CRC16
    localparam logic [15:0] CRC16_RESIDUE = 16'h800D;

endpackage

/* hw/usbRxCfgPkg.sv */
package usbRxCfgPkg;

    // ======================================================================
    // Receive datapath types
    // ======================================================================

    // One byte as it leaves the deserializer
    typedef logic [7:0] byte_t;

    // Receive FSM
    // recover is a single cycle that resets the decoder after EOP
    typedef enum logic [1:0] {
        waitSync,
        getPid,
        getData,
        recover
    } rxState_e;

    // Decoded line bit
    // valid is low for a removed stuff bit
    typedef struct packed {
        logic data;
        logic valid;
    } lineBit_t;

    // Byte handed from the engine to the output pipe
    // isData is low for the PID byte
    typedef struct packed {
        byte_t data;
        logic  isData;
    } rxByte_t;

endpackage

/* hw/nrziUnstuff.sv */
module nrziUnstuff (
    input  logic                  clk12_i,
    input  logic                  rstN_i,
    input  logic                  clr_i,
    input  logic                  line_i,
    output usbRxCfgPkg::lineBit_t bit_o,
    output logic                  stuffErr_o
);

    // Run length of decoded ones
    typedef logic [2:0] onesCnt_t;

    // After six ones the transmitter inserts a zero
    localparam onesCnt_t STUFF_AFTER = 3'd6;

    logic     prevLine;
    logic     decoded;
    logic     isStuffBit;
    onesCnt_t onesCnt;

    // ======================================================================
    // NRZI decode
    // ======================================================================

    // No level change between two samples means a one
    assign decoded = ~(line_i ^ prevLine);

    // This bit is the one following six ones
    assign isStuffBit = (onesCnt == STUFF_AFTER);

    // ======================================================================
    // Bit destuffing
    // ======================================================================

    always_ff @(posedge clk12_i or negedge rstN_i) begin
        if (!rstN_i) begin
            // Idle line is J, which is a high D+ level
            prevLine    <= 1'b1;
            onesCnt     <= '0;
            // Idle decodes as ones, none of them valid yet
            bit_o.data  <= 1'b1;
            bit_o.valid <= 1'b0;
            stuffErr_o  <= 1'b0;
        end else if (clr_i) begin
            // Back to idle after EOP
            prevLine    <= 1'b1;
            onesCnt     <= '0;
            bit_o.data  <= 1'b1;
            bit_o.valid <= 1'b0;
            stuffErr_o  <= 1'b0;
        end else begin
            prevLine    <= line_i;
            bit_o.data  <= decoded;
            // Stuff bit is removed from the stream
            bit_o.valid <= ~isStuffBit;
            // A seventh one is a stuffing violation
            stuffErr_o  <= isStuffBit & decoded;
            // Any zero, stuffed or not, restarts the run
            if (isStuffBit || !decoded) begin
                onesCnt <= '0;
            end else begin
                onesCnt <= onesCnt + 1'b1;
            end
        end
    end

endmodule

/* hw/usbCrcCheck.sv */
module usbCrcCheck (
    input  logic                  clk12_i,
    input  logic                  rstN_i,
    input  logic                  clr_i,
    input  logic                  sel16_i,
    input  usbRxCfgPkg::lineBit_t bit_i,
    output logic                  crcOk_o
);

    // USB polynomials, x^5+x^2+1 and x^16+x^15+x^2+1
    localparam logic [4:0]  POLY5  = 5'b00101;
    localparam logic [15:0] POLY16 = 16'h8005;

    logic [4:0]  crc5;
    logic [15:0] crc16;
    logic        fb5;
    logic        fb16;

    // ======================================================================
    // Serial CRC registers
    // ======================================================================

    // Feedback is the incoming bit against the top register bit
    assign fb5  = bit_i.data ^ crc5[4];
    assign fb16 = bit_i.data ^ crc16[15];

    always_ff @(posedge clk12_i or negedge rstN_i) begin
        if (!rstN_i) begin
            crc5  <= '1;
            crc16 <= '1;
        end else if (clr_i) begin
            // Preset to all ones at the start of the checked field
            crc5  <= '1;
            crc16 <= '1;
        end else if (bit_i.valid) begin
            // Stuff bits never reach the CRC
            crc5  <= {crc5[3:0], 1'b0} ^ (fb5 ? POLY5 : 5'b0);
            crc16 <= {crc16[14:0], 1'b0} ^ (fb16 ? POLY16 : 16'b0);
        end
    end

    // ======================================================================
    // Residue match
    // ======================================================================

    // With the CRC field shifted in too, a good packet leaves the fixed residue
    always_comb begin
        if (sel16_i) begin
            crcOk_o = (crc16 == usbPacketPkg::CRC16_RESIDUE);
        end else begin
            crcOk_o = (crc5 == usbPacketPkg::CRC5_RESIDUE);
        end
    end

endmodule

/* hw/usbRxEngine.sv */
module usbRxEngine (
    input  logic                  clk12_i,
    input  logic                  rstN_i,
    input  usbRxCfgPkg::lineBit_t bit_i,
    input  logic                  stuffErr_i,
    input  logic                  validLine_i,
    input  logic                  eopStrobe_i,
    input  logic                  crcOk_i,
    output logic                  decodeClr_o,
    output logic                  crcClr_o,
    output logic                  crc16Sel_o,
    output logic                  byteStb_o,
    output usbRxCfgPkg::rxByte_t  byte_o,
    output logic                  eopSeen_o,
    output logic                  useCrc16_o,
    output logic                  dropPkt_o
);

    usbRxCfgPkg::rxState_e state;
    usbRxCfgPkg::byte_t    shiftReg;
    usbRxCfgPkg::byte_t    nextShift;
    usbPacketPkg::pid_t    pidNib;
    usbPacketPkg::pid_t    pidCheck;
    logic [2:0]            bitCnt;
    logic                  inPacket;
    logic                  byteDone;
    logic                  pidOk;
    logic                  lineBad;
    logic                  dropReg;
    logic                  crcGood;
    logic                  finalCrcOk;
    logic                  useCrc16;

    // ======================================================================
    // Deserializer and decode
    // ======================================================================

    // LSB arrives first, so new bits enter at the top
    assign nextShift = {bit_i.data, shiftReg[7:1]};
    assign inPacket  = (state == usbRxCfgPkg::getPid) || (state == usbRxCfgPkg::getData);
    // Eighth valid bit of a byte is on the input
    assign byteDone  = inPacket && bit_i.valid && (bitCnt == 3'd7);

    // PID nibble first, its complement as the check nibble
    assign pidNib   = nextShift[3:0];
    assign pidCheck = nextShift[7:4];
    assign pidOk    = (pidCheck == ~pidNib);

    // Preset lands in place of the last PID bit, first payload bit is checked
    assign crcClr_o   = byteDone && (state == usbRxCfgPkg::getPid);
    assign crc16Sel_o = useCrc16;
    assign useCrc16_o = useCrc16;

    assign decodeClr_o = (state == usbRxCfgPkg::recover);
    assign eopSeen_o   = (state == usbRxCfgPkg::recover);

    // Final byte strobe can land in recover, use the live checker result then
    assign finalCrcOk = (byteStb_o && byte_o.isData) ? crcOk_i : crcGood;
    assign dropPkt_o  = dropReg || ((state == usbRxCfgPkg::recover) && !finalCrcOk);

    always_ff @(posedge clk12_i) begin
        // Sliding SYNC window while idle, valid bits only inside a packet
        if ((state == usbRxCfgPkg::waitSync) || (inPacket && bit_i.valid)) begin
            shiftReg <= nextShift;
        end
        if (byteDone) begin
            byte_o.data   <= nextShift;
            byte_o.isData <= (state == usbRxCfgPkg::getData);
        end
    end

    // ======================================================================
    // Receive FSM
    // ======================================================================

    always_ff @(posedge clk12_i or negedge rstN_i) begin
        if (!rstN_i) begin
            state     <= usbRxCfgPkg::waitSync;
            bitCnt    <= '0;
            byteStb_o <= 1'b0;
            lineBad   <= 1'b0;
            dropReg   <= 1'b0;
            crcGood   <= 1'b1;
            useCrc16  <= 1'b0;
        end else begin
            byteStb_o <= byteDone;
            lineBad   <= ~validLine_i;  // delayed like the decoded bit
            if (inPacket && bit_i.valid) begin
                bitCnt <= bitCnt + 1'b1;
            end
            // Line or stuffing faults anywhere after SYNC
            if (inPacket && (lineBad || stuffErr_i)) begin
                dropReg <= 1'b1;
            end
            unique case (state)
                usbRxCfgPkg::waitSync: begin
                    if (nextShift == usbPacketPkg::SYNC_PATTERN) begin
                        state   <= usbRxCfgPkg::getPid;
                        bitCnt  <= '0;
                        dropReg <= 1'b0;
                        // No payload means nothing to check
                        crcGood <= 1'b1;
                    end
                end
                usbRxCfgPkg::getPid: begin
                    if (byteDone) begin
                        useCrc16 <= (pidNib[1:0] == usbPacketPkg::DATA_PID_MASK);
                        if (!pidOk) begin
                            dropReg <= 1'b1;
                        end
                        state <= usbRxCfgPkg::getData;
                    end
                    // Handshake packets end right after the PID
                    if (eopStrobe_i) begin
                        state <= usbRxCfgPkg::recover;
                    end
                end
                usbRxCfgPkg::getData: begin
                    // Keep the verdict of the newest complete byte
                    if (byteStb_o && byte_o.isData) begin
                        crcGood <= crcOk_i;
                    end
                    if (eopStrobe_i) begin
                        state <= usbRxCfgPkg::recover;
                    end
                end
                usbRxCfgPkg::recover: begin
                    if (!finalCrcOk) begin
                        dropReg <= 1'b1;
                    end
                    state <= usbRxCfgPkg::waitSync;
                end
            endcase
        end
    end

endmodule

/* hw/rxBytePipe.sv */
module rxBytePipe (
    input  logic                 clk12_i,
    input  logic                 rstN_i,
    input  logic                 byteStb_i,
    input  usbRxCfgPkg::rxByte_t byte_i,
    input  logic                 eopSeen_i,
    input  logic                 useCrc16_i,
    input  logic                 dropPkt_i,
    input  logic                 rxAccept_i,
    output usbRxCfgPkg::byte_t   rxData_o,
    output logic                 rxValid_o,
    output logic                 rxLast_o,
    output logic                 keepPacket_o
);

    // Entry 0 is the newest byte, the last entry is the head
    localparam int DEPTH = 4;
    localparam int HEAD  = DEPTH - 1;

    usbRxCfgPkg::rxByte_t queue     [DEPTH];
    usbRxCfgPkg::rxByte_t nextQueue [DEPTH];
    usbRxCfgPkg::rxByte_t fillEntry;
    logic                 handshake;
    logic                 shift;
    logic                 flush;
    logic                 nextFlush;
    logic                 overrun;
    logic                 nextOverrun;
    logic                 queueBusy;

    // ======================================================================
    // Output handshake
    // ======================================================================

    assign rxData_o  = queue[HEAD].data;
    assign rxValid_o = queue[HEAD].isData;
    // Last payload byte when nothing behind it is data
    assign rxLast_o  = queue[HEAD].isData && !queue[HEAD-1].isData;
    assign handshake = rxValid_o && rxAccept_i;

    // Strobes always shift, flush shifts only into an empty or taken head
    assign shift     = byteStb_i || (flush && (handshake || !rxValid_o));
    assign fillEntry = byteStb_i ? byte_i : '0;

    assign queueBusy = queue[3].isData || queue[2].isData || queue[1].isData || queue[0].isData;

    // Unread head pushed out by a shift loses a byte
    assign nextOverrun  = (overrun && queueBusy) || (shift && rxValid_o && !rxAccept_i);
    assign keepPacket_o = !(dropPkt_i || overrun);

    // ======================================================================
    // Queue update
    // ======================================================================

    always_comb begin
        nextQueue = queue;
        if (shift) begin
            for (int i = HEAD; i > 0; i--) begin
                nextQueue[i] = queue[i-1];
            end
            nextQueue[0] = fillEntry;
        end else if (handshake) begin
            nextQueue[HEAD].isData = 1'b0;
        end
        // The two newest bytes of a data packet are its CRC16
        if (eopSeen_i && useCrc16_i) begin
            nextQueue[1].isData = 1'b0;
            nextQueue[0].isData = 1'b0;
        end
        // Flush until no payload waits behind the head
        nextFlush = (flush || eopSeen_i)
                    && (nextQueue[2].isData || nextQueue[1].isData || nextQueue[0].isData);
    end

    always_ff @(posedge clk12_i or negedge rstN_i) begin
        if (!rstN_i) begin
            queue   <= '{default: '0};
            flush   <= 1'b0;
            overrun <= 1'b0;
        end else begin
            queue   <= nextQueue;
            flush   <= nextFlush;
            overrun <= nextOverrun;
        end
    end

endmodule

/* hw/usbRxTop.sv */
module usbRxTop (
    input  logic               clk12_i,
    input  logic               rstN_i,
    input  logic               dataInP_i,
    input  logic               validLine_i,
    input  logic               eopStrobe_i,
    input  logic               rxAccept_i,
    output usbRxCfgPkg::byte_t rxData_o,
    output logic               rxValid_o,
    output logic               rxLast_o,
    output logic               keepPacket_o
);

    // ======================================================================
    // Internal wiring
    // ======================================================================

    usbRxCfgPkg::lineBit_t lineBit;
    usbRxCfgPkg::rxByte_t  rxByte;
    logic                  stuffErr;
    logic                  decodeClr;
    logic                  crcClr;
    logic                  crc16Sel;
    logic                  crcOk;
    logic                  byteStb;
    logic                  eopSeen;
    logic                  useCrc16;
    logic                  dropPkt;

    // Line decode
    nrziUnstuff nrziInst (
        .clk12_i    (clk12_i),
        .rstN_i     (rstN_i),
        .clr_i      (decodeClr),
        .line_i     (dataInP_i),
        .bit_o      (lineBit),
        .stuffErr_o (stuffErr)
    );

    // CRC over everything after the PID
    usbCrcCheck crcInst (
        .clk12_i (clk12_i),
        .rstN_i  (rstN_i),
        .clr_i   (crcClr),
        .sel16_i (crc16Sel),
        .bit_i   (lineBit),
        .crcOk_o (crcOk)
    );

    // Packet framing and error tracking
    usbRxEngine engineInst (
        .clk12_i     (clk12_i),
        .rstN_i      (rstN_i),
        .bit_i       (lineBit),
        .stuffErr_i  (stuffErr),
        .validLine_i (validLine_i),
        .eopStrobe_i (eopStrobe_i),
        .crcOk_i     (crcOk),
        .decodeClr_o (decodeClr),
        .crcClr_o    (crcClr),
        .crc16Sel_o  (crc16Sel),
        .byteStb_o   (byteStb),
        .byte_o      (rxByte),
        .eopSeen_o   (eopSeen),
        .useCrc16_o  (useCrc16),
        .dropPkt_o   (dropPkt)
    );

    // Byte output towards the backend
    rxBytePipe pipeInst (
        .clk12_i      (clk12_i),
        .rstN_i       (rstN_i),
        .byteStb_i    (byteStb),
        .byte_i       (rxByte),
        .eopSeen_i    (eopSeen),
        .useCrc16_i   (useCrc16),
        .dropPkt_i    (dropPkt),
        .rxAccept_i   (rxAccept_i),
        .rxData_o     (rxData_o),
        .rxValid_o    (rxValid_o),
        .rxLast_o     (rxLast_o),
        .keepPacket_o (keepPacket_o)
    );

endmodule

/* verification/usbRx_assert.sv */
module usbRxAssert (
    input logic               clk12_i,
    input logic               rstN_i,
    input logic               rxAccept_i,
    input usbRxCfgPkg::byte_t rxData_o,
    input logic               rxValid_o,
    input logic               rxLast_o,
    input logic               keepPacket_o
);

    // Last flag only marks a presented byte
    lastNeedsValid: assert property (@(posedge clk12_i) disable iff (!rstN_i)
        rxLast_o |-> rxValid_o)
        else $error("rxLast_o high while rxValid_o is low");

    // Waiting byte holds still unless an overrun has dropped the packet
    dataHeld: assert property (@(posedge clk12_i) disable iff (!rstN_i)
        (rxValid_o && !rxAccept_i) |=> ($stable(rxData_o) || !keepPacket_o))
        else $error("rxData_o changed while waiting for accept");

    // Queue comes out of reset empty
    idleAfterReset: assert property (@(posedge clk12_i)
        !rstN_i |=> !rxValid_o)
        else $error("rxValid_o high right after reset");

endmodule

bind usbRxTop usbRxAssert assertInst (
    .clk12_i      (clk12_i),
    .rstN_i       (rstN_i),
    .rxAccept_i   (rxAccept_i),
    .rxData_o     (rxData_o),
    .rxValid_o    (rxValid_o),
    .rxLast_o     (rxLast_o),
    .keepPacket_o (keepPacket_o)
);

/* verification/usbRxTb.sv */
module usbRxTb;

    localparam int BYTE_TIMEOUT  = 400;
    localparam int DRAIN_TIMEOUT = 600;
    // Accept stays low this long in the lag test, several byte times
    localparam int LAG_CYCLES    = 100;

    logic               clk12;
    logic               rstN;
    logic               dataInP;
    logic               validLine;
    logic               eopStrobe;
    logic               rxAccept;
    usbRxCfgPkg::byte_t rxData;
    logic               rxValid;
    logic               rxLast;
    logic               keepPacket;

    // Current test as read from the data file
    string              tokens[$];
    string              tag;
    string              inj;
    logic               expKeep;
    bit                 checkPayload;
    usbRxCfgPkg::byte_t pktBytes[$];
    usbRxCfgPkg::byte_t expBytes[$];

    // Stuffed bit stream before NRZI
    logic               lineBits[$];
    int                 onesRun;
    int                 lcgState = 37;
    int                 testErrors;
    int                 errCount  = 0;
    int                 testCount = 0;
    int                 failCount = 0;

    usbRxTop dut_i (
        .clk12_i      (clk12),
        .rstN_i       (rstN),
        .dataInP_i    (dataInP),
        .validLine_i  (validLine),
        .eopStrobe_i  (eopStrobe),
        .rxAccept_i   (rxAccept),
        .rxData_o     (rxData),
        .rxValid_o    (rxValid),
        .rxLast_o     (rxLast),
        .keepPacket_o (keepPacket)
    );

    initial begin
        clk12 = 1'b0;
        forever #4 clk12 = ~clk12;
    end

    // ======================================================================
    // Helpers
    // ======================================================================

    function automatic int nextRand();
        lcgState = (lcgState * 1103515245 + 12345) & 32'h7fff_ffff;
        return lcgState >>> 16;
    endfunction

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $finish;
    endtask

    task automatic checkByte(input usbRxCfgPkg::byte_t got, input usbRxCfgPkg::byte_t exp,
                             input int idx);
        if (got !== exp) begin
            $display("error rxData_o byte %0d: got %h expected %h", idx, got, exp);
            testErrors++;
        end
    endtask

    task automatic checkKeep(input logic got, input logic exp);
        if (got !== exp) begin
            $display("error keepPacket_o: got %h expected %h", got, exp);
            testErrors++;
        end
    endtask

    // Split a text line on white space
    task automatic tokenize(input string text);
        int  start;
        int  i;
        byte ch;
        tokens.delete();
        start = -1;
        for (i = 0; i <= text.len(); i++) begin
            ch = (i < text.len()) ? text.getc(i) : " ";
            if (ch == " " || ch == "\t" || ch == "\n" || ch == "\r") begin
                if (start >= 0) begin
                    tokens.push_back(text.substr(start, i - 1));
                    start = -1;
                end
            end else if (start < 0) begin
                start = i;
            end
        end
    endtask

    task automatic parseTest(input string text, output bit ok);
        int         section;
        int         i;
        int         rc;
        logic [7:0] value;
        ok = 1'b0;
        tokenize(text);
        if (tokens.size() < 4 || tokens[0].getc(0) == "#") begin
            return;
        end
        tag          = tokens[0];
        inj          = tokens[1];
        expKeep      = (tokens[2] == "1");
        checkPayload = 1'b1;
        section      = 0;
        pktBytes.delete();
        expBytes.delete();
        for (i = 3; i < tokens.size(); i++) begin
            if (tokens[i] == "|") begin
                section++;
            end else if (section == 2 && tokens[i] == "*") begin
                checkPayload = 1'b0;
            end else begin
                rc = $sscanf(tokens[i], "%h", value);
                if (rc != 1) begin
                    $display("unreadable byte %s in test %s", tokens[i], tag);
                    errCount++;
                end else if (section == 1) begin
                    pktBytes.push_back(value);
                end else begin
                    expBytes.push_back(value);
                end
            end
        end
        ok = (pktBytes.size() > 0);
    endtask

    // ======================================================================
    // Line side, bit stuffing and NRZI
    // ======================================================================

    // A zero follows every run of six ones
    task automatic pushStuffed(input logic b);
        lineBits.push_back(b);
        onesRun = b ? onesRun + 1 : 0;
        if (onesRun == 6) begin
            lineBits.push_back(1'b0);
            onesRun = 0;
        end
    endtask

    task automatic sendPacket();
        int   i;
        int   b;
        int   badIdx;
        logic level;
        lineBits.delete();
        onesRun = 0;
        badIdx  = -1;
        // SYNC as seven zeros and a one
        for (i = 0; i < 8; i++) begin
            pushStuffed(i == 7);
        end
        for (i = 0; i < pktBytes.size(); i++) begin
            // Faults go in after the first payload byte
            if (i == 2 && inj == "stuff") begin
                repeat (7) lineBits.push_back(1'b1);
                onesRun = 0;
            end
            if (i == 2 && inj == "line") begin
                badIdx = lineBits.size() + 3;
            end
            for (b = 0; b < 8; b++) begin
                pushStuffed(pktBytes[i][b]);
            end
        end
        // Idle J is high, a zero toggles the line
        level = 1'b1;
        for (i = 0; i < lineBits.size(); i++) begin
            if (!lineBits[i]) begin
                level = ~level;
            end
            @(posedge clk12);
            dataInP   <= level;
            validLine <= (i != badIdx);
        end
        @(posedge clk12);
        dataInP   <= 1'b1;
        validLine <= 1'b1;
        eopStrobe <= 1'b1;
        @(posedge clk12);
        eopStrobe <= 1'b0;
    endtask

    // ======================================================================
    // Backend side
    // ======================================================================

    task automatic collectBytes();
        int idle;
        int cycle;
        int waitLeft;
        int idx;
        bit done;
        idle     = 0;
        cycle    = 0;
        idx      = 0;
        done     = 1'b0;
        waitLeft = nextRand() % 4;
        while (!done) begin
            @(posedge clk12);
            if (inj == "lag" && cycle < LAG_CYCLES) begin
                rxAccept <= 1'b0;
            end else if (waitLeft > 0) begin
                rxAccept <= 1'b0;
                waitLeft--;
            end else begin
                rxAccept <= 1'b1;
            end
            // Values here are what the next rising edge sees
            @(negedge clk12);
            cycle++;
            idle++;
            if (rxValid && rxAccept) begin
                if (checkPayload && idx < expBytes.size()) begin
                    checkByte(rxData, expBytes[idx], idx);
                end else if (checkPayload) begin
                    $display("byte %0d arrived beyond the expected payload", idx);
                    testErrors++;
                end
                idx++;
                idle     = 0;
                waitLeft = nextRand() % 4;
                if (rxLast) begin
                    checkKeep(keepPacket, expKeep);
                    if (checkPayload && idx != expBytes.size()) begin
                        $display("payload ended after %0d bytes, %0d expected",
                                 idx, expBytes.size());
                        testErrors++;
                    end
                    done = 1'b1;
                end
            end
            if (!done && idle > BYTE_TIMEOUT) begin
                abortRun("no final payload byte arrived within the timeout");
            end
        end
    endtask

    // Handshake packets leave the queue empty, keep settles in recover
    task automatic checkNoPayload();
        repeat (4) begin
            @(negedge clk12);
            if (rxValid) begin
                $display("a byte appeared for a packet without payload");
                testErrors++;
            end
        end
        checkKeep(keepPacket, expKeep);
    endtask

    task automatic drainQueue();
        int quiet;
        int waited;
        quiet  = 0;
        waited = 0;
        while (quiet < 8) begin
            @(posedge clk12);
            rxAccept <= 1'b1;
            @(negedge clk12);
            quiet = rxValid ? 0 : quiet + 1;
            waited++;
            if (waited > DRAIN_TIMEOUT) begin
                abortRun("output queue did not drain within the timeout");
            end
        end
        @(posedge clk12);
        rxAccept <= 1'b0;
    endtask

    task automatic runTest();
        testErrors = 0;
        if (checkPayload && expBytes.size() == 0) begin
            sendPacket();
            checkNoPayload();
        end else begin
            fork
                sendPacket();
                collectBytes();
            join
        end
        drainQueue();
        testCount++;
        errCount += testErrors;
        if (testErrors == 0) begin
            $display("test %s ok", tag);
        end else begin
            failCount++;
            $display("test %s failed with %0d errors", tag, testErrors);
        end
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================

    initial begin
        int    fd;
        int    status;
        bit    ok;
        string text;
        rstN      = 1'b0;
        dataInP   = 1'b1;
        validLine = 1'b1;
        eopStrobe = 1'b0;
        rxAccept  = 1'b0;
        repeat (16) @(posedge clk12);
        rstN <= 1'b1;
        repeat (4) @(posedge clk12);
        fd = $fopen("verification/usbRxInput.txt", "r");
        if (fd == 0) begin
            abortRun("cannot open the stimulus file");
        end else begin
            while (!$feof(fd)) begin
                status = $fgets(text, fd);
                if (status != 0) begin
                    parseTest(text, ok);
                    if (ok) begin
                        runTest();
                    end
                end
            end
            $fclose(fd);
            $display("tests %0d, failing %0d, errors %0d", testCount, failCount, errCount);
            if (errCount == 0 && testCount > 0) begin
                $display("Regression passed");
            end else begin
                $display("Regression failed");
            end
            $finish;
        end
    end

endmodule

/* usbRx.f */
hw/usbPacketPkg.sv
hw/usbRxCfgPkg.sv
hw/nrziUnstuff.sv
hw/usbCrcCheck.sv
hw/usbRxEngine.sv
hw/rxBytePipe.sv
hw/usbRxTop.sv
verification/usbRx_assert.sv
verification/usbRxTb.sv

/* Bender.yml */
package:
  name: usbRx

sources:
  - hw/usbPacketPkg.sv
  - hw/usbRxCfgPkg.sv
  - hw/nrziUnstuff.sv
  - hw/usbCrcCheck.sv
  - hw/usbRxEngine.sv
  - hw/rxBytePipe.sv
  - hw/usbRxTop.sv
  - target: simulation
    files:
      - verification/usbRx_assert.sv
      - verification/usbRxTb.sv

/* verification/usbRxInput.txt */
# tag injection keep | packet bytes, PID first and CRC included | expected payload bytes
# injection is none, stuff, line or lag; a payload of * is not compared byte by byte
data0Clean none 1 | C3 80 06 00 01 00 00 40 00 DD 94 | 80 06 00 01 00 00 40 00
tokenSetup none 1 | 2D 00 10 | 00 10
tokenIn none 1 | 69 00 10 | 00 10
handshakeAck none 1 | D2 |
data0BadCrc none 0 | C3 80 06 00 01 00 00 40 00 DD 95 | 80 06 00 01 00 00 40 00
pidMismatch none 0 | C2 80 06 00 01 00 00 40 00 DD 94 | *
stuffViolation stuff 0 | C3 80 06 00 01 00 00 40 00 DD 94 | *
lineInvalid line 0 | C3 80 06 00 01 00 00 40 00 DD 94 | 80 06 00 01 00 00 40 00
acceptLag lag 0 | C3 80 06 00 01 00 00 40 00 DD 94 | *
afterLag none 1 | C3 80 06 00 01 00 00 40 00 DD 94 | 80 06 00 01 00 00 40 00
